// File: hw/cam_pkg.sv
// shared widths, counts and enums for the dual-camera pixel front end
package cam_pkg;

    // lane geometry
    localparam int NUM_CAMS   = 2;  // camera lanes
    localparam int BYTE_W     = 8;  // camera bus width
    localparam int PIX_W      = 16; // rgb565 word
    localparam int CHAN_W     = 8;  // output colour channel
    localparam int LANE_IDX_W = 1;  // enough bits for a lane index

    // power-up timing, scaled down for simulation
    localparam int RST_DELAY_CYCLES = 100; // camera reset hold after reset
    localparam int HEARTBEAT_CYCLES = 50;  // cycles between blinker toggles
    localparam int DELAY_CNT_W      = 7;   // holds RST_DELAY_CYCLES
    localparam int HB_CNT_W         = 6;   // holds HEARTBEAT_CYCLES-1

    // per-lane byte pairing states
    typedef enum logic [1:0] {
        PACK_WAIT_FRAME = 2'd0, // idle until first frame start
        PACK_HI         = 2'd1, // next byte is the upper half
        PACK_LO         = 2'd2  // next byte completes the word
    } pack_state_e;

    // upper nibble of a command byte, lower nibble is the value
    typedef enum logic [3:0] {
        CMD_NOP     = 4'h0, // no operation
        CMD_SEL_SRC = 4'h1  // pick the lane driving the video output
    } cmd_op_e;

endpackage

// File: hw/power_on_seq.sv
// power-up sequencer holding camera resets for a fixed delay, plus heartbeat blinker
`timescale 1ns/100ps

module power_on_seq
    import cam_pkg::*;
(
    input  logic                core_clk,
    input  logic                reset_i,
    output logic [NUM_CAMS-1:0] cam_rst_n_o, // active-low sensor resets
    output logic                lane_en_o,   // releases the pixel lanes
    output logic                init_done_o,
    output logic                heartbeat_o
);

    logic [DELAY_CNT_W-1:0] dly_cnt_q; // saturates at RST_DELAY_CYCLES
    logic                   done_q;    // delay elapsed
    logic [HB_CNT_W-1:0]    hb_cnt_q;
    logic                   hb_q;

    // counts edges since reset, stops at the limit
    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            dly_cnt_q <= '0;
            done_q    <= 1'b0;
        end else begin
            if (dly_cnt_q != DELAY_CNT_W'(RST_DELAY_CYCLES)) begin
                dly_cnt_q <= dly_cnt_q + 1'b1;
            end
            if (dly_cnt_q == DELAY_CNT_W'(RST_DELAY_CYCLES)) begin
                done_q <= 1'b1; // sticky until next reset
            end
        end
    end

    // blinker only runs once init is done
    always_ff @(posedge core_clk) begin
        if (reset_i || !done_q) begin
            hb_cnt_q <= '0;
            hb_q     <= 1'b1; // led on while waiting
        end else if (hb_cnt_q == HB_CNT_W'(HEARTBEAT_CYCLES - 1)) begin
            hb_cnt_q <= '0;
            hb_q     <= ~hb_q;
        end else begin
            hb_cnt_q <= hb_cnt_q + 1'b1;
        end
    end

    assign cam_rst_n_o = {NUM_CAMS{done_q}}; // all sensors leave reset together
    assign lane_en_o   = done_q;
    assign init_done_o = done_q;
    assign heartbeat_o = hb_q;

    // lanes only run once the delay counter has saturated
    a_en_after_delay: assert property (
        @(posedge core_clk) disable iff (reset_i)
        lane_en_o |-> dly_cnt_q == DELAY_CNT_W'(RST_DELAY_CYCLES)
    );

endmodule

// File: hw/pixel_pack_lane.sv
// one camera lane: input capture, frame gating and byte pairing into reordered rgb565
`timescale 1ns/100ps

module pixel_pack_lane
    import cam_pkg::*;
(
    input  logic              core_clk,
    input  logic              reset_i,
    input  logic              lane_en_i,   // from power-up sequencer
    input  logic [BYTE_W-1:0] cam_data_i,
    input  logic              cam_href_i,
    input  logic              cam_vsync_i,
    output logic [PIX_W-1:0]  pix_o,       // {low5, mid6, high5} of the paired word
    output logic              pix_valid_o, // one pulse per word
    output logic              vsync_o
);

    logic [BYTE_W-1:0] data_q;  // registered camera bus
    logic              href_q;
    logic              vsync_q;
    logic              vsync_d; // previous vsync_q, for edge detect
    logic              vs_rise;

    pack_state_e       state_q;
    logic [BYTE_W-1:0] hi_byte_q; // first half of the pair
    logic [PIX_W-1:0]  word;      // raw pair before swap
    logic [PIX_W-1:0]  pix_q;
    logic              pix_valid_q;

    // input capture, edge E
    always_ff @(posedge core_clk) begin
        data_q <= cam_data_i; // payload, no reset
        if (reset_i) begin
            href_q  <= 1'b0;
            vsync_q <= 1'b0;
            vsync_d <= 1'b0;
        end else begin
            href_q  <= cam_href_i;
            vsync_q <= cam_vsync_i;
            vsync_d <= vsync_q;
        end
    end

    assign vs_rise = vsync_q & ~vsync_d; // frame start
    assign word    = {hi_byte_q, data_q};

    // pairing fsm, runs at edge E+1 on the captured byte
    always_ff @(posedge core_clk) begin
        if (reset_i || !lane_en_i) begin
            state_q     <= PACK_WAIT_FRAME;
            pix_valid_q <= 1'b0;
        end else begin
            pix_valid_q <= 1'b0; // default, single-cycle pulse
            case (state_q)
                PACK_WAIT_FRAME: begin
                    if (vs_rise) begin
                        state_q <= PACK_HI; // first frame seen
                    end
                end
                PACK_HI: begin
                    if (!vs_rise && href_q) begin
                        state_q <= PACK_LO;
                    end
                end
                PACK_LO: begin
                    if (!vs_rise && href_q) begin
                        pix_valid_q <= 1'b1; // pair complete
                    end
                    state_q <= PACK_HI; // unpaired byte is dropped
                end
                default: state_q <= PACK_WAIT_FRAME;
            endcase
        end
    end

    // payload side of the pairing, no reset
    always_ff @(posedge core_clk) begin
        if (state_q == PACK_HI && href_q) begin
            hi_byte_q <= data_q;
        end
        if (state_q == PACK_LO && href_q) begin
            pix_q <= {word[4:0], word[10:5], word[15:11]}; // swap red and blue
        end
    end

    assign pix_o       = pix_q;
    assign pix_valid_o = pix_valid_q;
    assign vsync_o     = vsync_d; // lines up with pix_valid_o timing

    // lanes stay silent until the sequencer releases them
    a_no_valid_when_off: assert property (
        @(posedge core_clk) disable iff (reset_i) !lane_en_i |-> !pix_valid_o
    );

endmodule

// File: hw/video_out_mux.sv
// command-driven lane select with rgb565 to rgb888 expansion and registered syncs
`timescale 1ns/100ps

module video_out_mux
    import cam_pkg::*;
(
    input  logic                           core_clk,
    input  logic                           reset_i,
    input  logic                           lane_en_i,
    input  logic [BYTE_W-1:0]              cmd_i,        // [7:4] opcode, [3:0] value
    input  logic                           cmd_valid_i,  // one-cycle strobe
    input  logic [NUM_CAMS-1:0][PIX_W-1:0] lane_pix_i,
    input  logic [NUM_CAMS-1:0]            lane_valid_i,
    input  logic [NUM_CAMS-1:0]            lane_vsync_i,
    output logic [CHAN_W-1:0]              r_o,
    output logic [CHAN_W-1:0]              g_o,
    output logic [CHAN_W-1:0]              b_o,
    output logic                           de_o,
    output logic                           vs_o
);

    cmd_op_e               cmd_op;
    logic [3:0]            cmd_val;
    logic [LANE_IDX_W-1:0] sel_q;   // current source lane
    logic [PIX_W-1:0]      sel_pix;
    logic [CHAN_W-1:0]     r_q;
    logic [CHAN_W-1:0]     g_q;
    logic [CHAN_W-1:0]     b_q;
    logic                  de_q;
    logic                  vs_q;

    assign cmd_op  = cmd_op_e'(cmd_i[7:4]);
    assign cmd_val = cmd_i[3:0];

    // command decode, new selection seen on the edge after the strobe
    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            sel_q <= '0; // lane 0 after reset
        end else if (cmd_valid_i) begin
            case (cmd_op)
                CMD_NOP: ;
                CMD_SEL_SRC: begin
                    if (cmd_val < NUM_CAMS) begin
                        sel_q <= cmd_val[LANE_IDX_W-1:0]; // out-of-range value ignored
                    end
                end
                default: ; // unknown opcodes do nothing
            endcase
        end
    end

    assign sel_pix = lane_pix_i[sel_q];

    // output stage
    always_ff @(posedge core_clk) begin
        r_q <= {sel_pix[15:11], {(CHAN_W-5){1'b0}}}; // left-aligned, zero padded
        g_q <= {sel_pix[10:5], {(CHAN_W-6){1'b0}}};
        b_q <= {sel_pix[4:0], {(CHAN_W-5){1'b0}}};
        if (reset_i) begin
            de_q <= 1'b0;
            vs_q <= 1'b0;
        end else begin
            de_q <= lane_en_i & lane_valid_i[sel_q];
            vs_q <= lane_vsync_i[sel_q];
        end
    end

    assign r_o  = r_q;
    assign g_o  = g_q;
    assign b_o  = b_q;
    assign de_o = de_q;
    assign vs_o = vs_q;

    // selection only moves on a select command naming an existing lane
    a_sel_guarded: assert property (
        @(posedge core_clk) disable iff (reset_i)
        !(cmd_valid_i && cmd_op == CMD_SEL_SRC && cmd_val < NUM_CAMS) |=> $stable(sel_q)
    );

endmodule

// File: hw/video_pipe_top.sv
// dual-camera front end top: sequencer, per-camera pairing lanes and output mux
`timescale 1ns/100ps

module video_pipe_top
    import cam_pkg::*;
(
    input  logic                            core_clk,
    input  logic                            reset_i,
    input  logic [NUM_CAMS-1:0][BYTE_W-1:0] cam_data_i,
    input  logic [NUM_CAMS-1:0]             cam_href_i,
    input  logic [NUM_CAMS-1:0]             cam_vsync_i,
    input  logic [BYTE_W-1:0]               cmd_i,
    input  logic                            cmd_valid_i,
    output logic [NUM_CAMS-1:0]             cam_rst_n_o,
    output logic                            init_done_o,
    output logic                            heartbeat_o,
    output logic [CHAN_W-1:0]               r_o,
    output logic [CHAN_W-1:0]               g_o,
    output logic [CHAN_W-1:0]               b_o,
    output logic                            de_o,
    output logic                            vs_o
);

    logic                           lane_en;    // lanes released after delay
    logic [NUM_CAMS-1:0][PIX_W-1:0] lane_pix;
    logic [NUM_CAMS-1:0]            lane_valid;
    logic [NUM_CAMS-1:0]            lane_vsync;

    power_on_seq u_power_on_seq (
        .core_clk    (core_clk),
        .reset_i     (reset_i),
        .cam_rst_n_o (cam_rst_n_o),
        .lane_en_o   (lane_en),
        .init_done_o (init_done_o),
        .heartbeat_o (heartbeat_o)
    );

    // one pairing lane per camera
    for (genvar g = 0; g < NUM_CAMS; g++) begin : g_lane
        pixel_pack_lane u_lane (
            .core_clk    (core_clk),
            .reset_i     (reset_i),
            .lane_en_i   (lane_en),
            .cam_data_i  (cam_data_i[g]),
            .cam_href_i  (cam_href_i[g]),
            .cam_vsync_i (cam_vsync_i[g]),
            .pix_o       (lane_pix[g]),
            .pix_valid_o (lane_valid[g]),
            .vsync_o     (lane_vsync[g])
        );
    end

    video_out_mux u_video_out_mux (
        .core_clk     (core_clk),
        .reset_i      (reset_i),
        .lane_en_i    (lane_en),
        .cmd_i        (cmd_i),
        .cmd_valid_i  (cmd_valid_i),
        .lane_pix_i   (lane_pix),
        .lane_valid_i (lane_valid),
        .lane_vsync_i (lane_vsync),
        .r_o          (r_o),
        .g_o          (g_o),
        .b_o          (b_o),
        .de_o         (de_o),
        .vs_o         (vs_o)
    );

endmodule

// File: sim/tb_video_pipe.sv
// testbench for the dual-camera front end, covering power-up, heartbeat, pairing and selection
`timescale 1ns/100ps

module tb_video_pipe
    import cam_pkg::*;
();

    localparam int NUM_ROWS       = 8;
    localparam int WATCH_CYCLES   = 5; // cycles watched after each low byte
    localparam int TIMEOUT_CYCLES = (RST_DELAY_CYCLES + 20 * NUM_ROWS) * 2;

    // columns are {cmd_valid, cmd byte, lane expected at the output}
    localparam logic [9:0] ROW_CTRL [NUM_ROWS] = '{
        {1'b0, 8'h00, 1'b0}, // lane 0 after reset
        {1'b0, 8'h00, 1'b0},
        {1'b1, 8'h05, 1'b0}, // nop with a value
        {1'b1, 8'h11, 1'b1}, // select lane 1
        {1'b1, 8'h12, 1'b1}, // no lane 2, ignored
        {1'b1, 8'h30, 1'b1}, // unknown opcode
        {1'b1, 8'h10, 1'b0}, // back to lane 0
        {1'b1, 8'h71, 1'b0}  // unknown opcode again
    };

    logic                            core_clk;
    logic                            reset_i;
    logic [NUM_CAMS-1:0][BYTE_W-1:0] cam_data;
    logic [NUM_CAMS-1:0]             cam_href;
    logic [NUM_CAMS-1:0]             cam_vsync;
    logic [BYTE_W-1:0]               cmd;
    logic                            cmd_valid;
    logic [NUM_CAMS-1:0]             cam_rst_n;
    logic                            init_done;
    logic                            heartbeat;
    logic [CHAN_W-1:0]               r_out;
    logic [CHAN_W-1:0]               g_out;
    logic [CHAN_W-1:0]               b_out;
    logic                            de;
    logic                            vs;

    integer seed           = 32'hed87;
    int     cycle_cnt      = 0;
    int     errors         = 0;
    int     tests_run      = 0;
    int     tests_failed   = 0;
    int     test_err_start = 0; // error count when the current test began

    video_pipe_top dut (
        .core_clk    (core_clk),
        .reset_i     (reset_i),
        .cam_data_i  (cam_data),
        .cam_href_i  (cam_href),
        .cam_vsync_i (cam_vsync),
        .cmd_i       (cmd),
        .cmd_valid_i (cmd_valid),
        .cam_rst_n_o (cam_rst_n),
        .init_done_o (init_done),
        .heartbeat_o (heartbeat),
        .r_o         (r_out),
        .g_o         (g_out),
        .b_o         (b_out),
        .de_o        (de),
        .vs_o        (vs)
    );

    initial begin
        core_clk = 1'b0;
        forever #50 core_clk = ~core_clk; // 100 ns period
    end

    always @(posedge core_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // red lands on the camera word's low five bits after the swap
    function automatic logic [3*CHAN_W-1:0] expand_swapped(input logic [PIX_W-1:0] word);
        expand_swapped = {word[4:0], 3'b000, word[10:5], 2'b00, word[15:11], 3'b000};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("MISMATCH %s: got %h, expected %h (cycle %0d)", name, got, exp, cycle_cnt);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err_start) begin
            $display("test %-16s ok", name);
        end else begin
            tests_failed++;
            $display("test %-16s failed, %0d errors", name, errors - test_err_start);
        end
    endtask

    // new byte per camera on the next rising edge
    task automatic drive_bytes(input logic [NUM_CAMS-1:0][BYTE_W-1:0] data,
                               input logic [NUM_CAMS-1:0] href);
        @(posedge core_clk);
        cam_data  <= data;
        cam_href  <= href;
        cmd_valid <= 1'b0; // command strobe lasts one cycle
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            drive_bytes('0, '0);
            @(negedge core_clk);
            if (de !== 1'b0) report_mismatch("de_o", de, 0);
        end
    endtask

    // one pair on every lane, the selected lane's pixel must come out
    task automatic send_pair(input logic [NUM_CAMS-1:0][BYTE_W-1:0] hi,
                             input logic [NUM_CAMS-1:0][BYTE_W-1:0] lo,
                             input logic [LANE_IDX_W-1:0] sel);
        logic [3*CHAN_W-1:0] exp_rgb;
        exp_rgb = expand_swapped({hi[sel], lo[sel]});
        drive_bytes(hi, '1);
        drive_bytes(lo, '1);
        // de_o is due three edges after the low byte reaches the pins
        for (int i = 1; i <= WATCH_CYCLES; i++) begin
            drive_bytes('0, '0);
            @(negedge core_clk);
            if (de !== (i == 3)) report_mismatch("de_o", de, i == 3);
            if (i == 3) begin
                if (r_out !== exp_rgb[23:16]) report_mismatch("r_o", r_out, exp_rgb[23:16]);
                if (g_out !== exp_rgb[15:8]) report_mismatch("g_o", g_out, exp_rgb[15:8]);
                if (b_out !== exp_rgb[7:0]) report_mismatch("b_o", b_out, exp_rgb[7:0]);
            end
        end
    endtask

    initial begin
        logic                            exp_on;
        logic                            hb_prev;
        int                              interval;
        int                              toggles;
        logic                            use_cmd;
        logic [BYTE_W-1:0]               cmd_byte;
        logic [LANE_IDX_W-1:0]           sel;
        logic [31:0]                     rnd;
        logic [NUM_CAMS-1:0][BYTE_W-1:0] hi;
        logic [NUM_CAMS-1:0][BYTE_W-1:0] lo;

        reset_i   = 1'b1;
        cam_data  = '0;
        cam_href  = '0;
        cam_vsync = '0;
        cmd       = '0;
        cmd_valid = 1'b0;
        repeat (2) @(posedge core_clk);
        reset_i <= 1'b0;

        // k counts edges with reset low
        test_err_start = errors;
        for (int k = 1; k <= RST_DELAY_CYCLES + 1; k++) begin
            @(posedge core_clk);
            @(negedge core_clk);
            exp_on = (k > RST_DELAY_CYCLES);
            if (init_done !== exp_on) report_mismatch("init_done_o", init_done, exp_on);
            if (cam_rst_n !== {NUM_CAMS{exp_on}}) begin
                report_mismatch("cam_rst_n_o", cam_rst_n, {NUM_CAMS{exp_on}});
            end
            if (heartbeat !== 1'b1) report_mismatch("heartbeat_o", heartbeat, 1);
        end
        end_test("reset release");

        test_err_start = errors;
        hb_prev  = heartbeat;
        interval = 0;
        toggles  = 0;
        while (toggles < 3 && interval <= 2 * HEARTBEAT_CYCLES) begin
            @(negedge core_clk);
            interval++;
            if (heartbeat !== hb_prev) begin
                if (interval != HEARTBEAT_CYCLES) begin
                    errors++;
                    $display("heartbeat_o toggled after %0d cycles, not %0d",
                             interval, HEARTBEAT_CYCLES);
                end
                hb_prev  = heartbeat;
                interval = 0;
                toggles++;
            end
        end
        if (toggles < 3) begin
            errors++;
            $display("heartbeat_o stopped toggling after %0d toggles", toggles);
        end
        end_test("heartbeat");

        // lanes are enabled but have seen no frame start yet
        test_err_start = errors;
        drive_bytes({8'h5a, 8'hc3}, '1);
        drive_bytes({8'ha5, 8'h3c}, '1);
        expect_quiet(6);
        end_test("no frame start");

        // vs_o follows the vsync pins by three edges
        test_err_start = errors;
        @(posedge core_clk);
        cam_vsync <= '1;
        @(posedge core_clk);
        cam_vsync <= '0;
        for (int i = 1; i <= 3; i++) begin
            drive_bytes('0, '0);
            @(negedge core_clk);
            if (vs !== (i == 2)) report_mismatch("vs_o", vs, i == 2);
            if (de !== 1'b0) report_mismatch("de_o", de, 0);
        end
        end_test("frame start");

        for (int row = 0; row < NUM_ROWS; row++) begin
            test_err_start = errors;
            {use_cmd, cmd_byte, sel} = ROW_CTRL[row];
            for (int cam = 0; cam < NUM_CAMS; cam++) begin
                rnd     = $random(seed);
                hi[cam] = rnd[15:8];
                lo[cam] = rnd[7:0];
            end
            if (use_cmd) begin
                @(posedge core_clk);
                cmd       <= cmd_byte;
                cmd_valid <= 1'b1;
            end
            send_pair(hi, lo, sel);
            end_test($sformatf("pixel row %0d", row));
        end

        // lone high byte, then href drops
        test_err_start = errors;
        drive_bytes({8'h81, 8'h7e}, '1);
        expect_quiet(6);
        // the next pair only lines up if the lone byte was dropped
        send_pair({8'h96, 8'h4b}, {8'h2d, 8'he1}, sel);
        end_test("broken pair");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
hw/cam_pkg.sv
hw/power_on_seq.sv
hw/pixel_pack_lane.sv
hw/video_out_mux.sv
hw/video_pipe_top.sv
sim/tb_video_pipe.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the video pipe testbench with Verilator, runs it and scans the log
set -u
cd "$(dirname "$0")" || exit 1

top=tb_video_pipe
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$top" -f project.f > build.log 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    cat build.log
    echo "build failed with status $status"
    exit 1
fi

"./obj_dir/V$top" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$log"; then
    exit 1
fi
exit 0
